//--- src/lmfe_macros.svh
// running median filter constants

`ifndef LMFE_MACROS_SVH
`define LMFE_MACROS_SVH

// pixel width in bits
`define LMF_PIX_W 8

// number of samples in the sliding window
// keep this odd so that one cell holds the median
`define LMF_WIN 49

// position of the median inside the ascending list
`define LMF_MED_IDX ((`LMF_WIN) / 2)

// largest pixel value
// also the contents of an empty slot after reset
`define LMF_PIX_MAX {`LMF_PIX_W{1'b1}}

// smallest pixel value
// seen by the first cell as its lower neighbour
`define LMF_PIX_MIN {`LMF_PIX_W{1'b0}}

// width of the window fill counter
// must hold the value LMF_WIN
`define LMF_FILL_W 6

`endif

//--- src/lmfe_pkg.sv
// median filter shared types

`include "lmfe_macros.svh"

package lmfe_pkg;

  // one sample of the pixel stream
  typedef logic [`LMF_PIX_W-1:0] pixel_t;

  // update sent to every cell of the sorted list
  // en marks a cycle in which the list changes,
  // ins enters the list and one copy of del leaves it
  typedef struct packed {
    logic   en;
    pixel_t ins;
    pixel_t del;
  } sort_update_t;

endpackage

//--- src/window_feeder.sv
// window delay line and update source

`timescale 1ns/10ps

`include "lmfe_macros.svh"

module window_feeder import lmfe_pkg::*; (
  input  logic         clk,
  input  logic         RST,
  input  pixel_t       pix,
  input  logic         in_en,
  output sort_update_t upd
);

  // last LMF_WIN accepted pixels
  // slot 0 is the newest, the top slot the oldest
  pixel_t line_q [`LMF_WIN];

  // sample that drops out of the window on the next accept
  pixel_t oldest;

  assign oldest = line_q[`LMF_WIN-1];

  // delay line
  // empty slots read as the maximum pixel, matching the cells
  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < `LMF_WIN; i++) begin
        line_q[i] <= `LMF_PIX_MAX;
      end
    end else if (in_en) begin
      for (int i = `LMF_WIN-1; i > 0; i--) begin
        line_q[i] <= line_q[i-1];
      end
      line_q[0] <= pix;
    end
  end

  // strobe of the update
  // one pulse per accepted pixel, gaps pass straight through
  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      upd.en <= 1'b0;
    end else begin
      upd.en <= in_en;
    end
  end

  // insert and delete values
  // the pair keeps the cell contents equal to the delay line
  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      upd.ins <= `LMF_PIX_MAX;
      upd.del <= `LMF_PIX_MAX;
    end else if (in_en) begin
      upd.ins <= pix;
      upd.del <= oldest;
    end
  end

endmodule

//--- src/sort_cell.sv
// one cell of the sorted window list

`timescale 1ns/10ps

`include "lmfe_macros.svh"

module sort_cell import lmfe_pkg::*; (
  input  logic         clk,
  input  logic         RST,
  input  sort_update_t upd,
  input  pixel_t       prev,
  input  pixel_t       next,
  output pixel_t       value
);

  // direction of the move
  // a smaller insert pushes entries up, a larger one pulls them down
  logic   ins_below;
  logic   ins_above;

  // cell lies between the two values and has to move
  logic   move_up;
  logic   move_down;

  // candidate values for the two directions
  pixel_t up_val;
  pixel_t down_val;

  pixel_t value_d;

  assign ins_below = upd.ins < upd.del;
  assign ins_above = upd.ins > upd.del;

  // range (ins, del] when shifting up
  assign move_up   = upd.en && ins_below &&
                     (value > upd.ins) && (value <= upd.del);

  // range [del, ins) when shifting down
  assign move_down = upd.en && ins_above &&
                     (value < upd.ins) && (value >= upd.del);

  // take the lower neighbour unless the insert lands here
  assign up_val   = (prev > upd.ins) ? prev : upd.ins;

  // take the upper neighbour unless the insert lands here
  assign down_val = (next < upd.ins) ? next : upd.ins;

  // equal insert and delete leave the list unchanged
  always_comb begin
    value_d = value;
    if (move_up) begin
      value_d = up_val;
    end else if (move_down) begin
      value_d = down_val;
    end
  end

  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      value <= `LMF_PIX_MAX;
    end else begin
      value <= value_d;
    end
  end

endmodule

//--- src/median_output.sv
// median register and valid strobe

`timescale 1ns/10ps

`include "lmfe_macros.svh"

module median_output import lmfe_pkg::*; (
  input  logic   clk,
  input  logic   RST,
  input  logic   upd_en,
  input  pixel_t median,
  output logic   out_valid,
  output pixel_t dout
);

  // update strobe aligned with the settled cells
  logic                   en_d;

  // number of updates seen since reset, stops at LMF_WIN
  logic [`LMF_FILL_W-1:0] fill_cnt;

  // window holds only real samples once this update lands
  logic                   window_full;

  // emit a result this cycle
  logic                   fire;

  // cells change one edge after upd, so wait one cycle
  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      en_d <= 1'b0;
    end else begin
      en_d <= upd_en;
    end
  end

  // fill counter
  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      fill_cnt <= '0;
    end else if (en_d && (fill_cnt < `LMF_WIN)) begin
      fill_cnt <= fill_cnt + 1'b1;
    end
  end

  // count of LMF_WIN-1 plus the current update is a full window
  assign window_full = fill_cnt >= (`LMF_WIN - 1);
  assign fire        = en_d && window_full;

  // result register
  // dout keeps the last median between strobes
  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
      dout      <= '0;
    end else begin
      out_valid <= fire;
      if (fire) begin
        dout <= median;
      end
    end
  end

endmodule

//--- src/lmfe_top.sv
// streaming running median filter

`timescale 1ns/10ps

`include "lmfe_macros.svh"

module lmfe_top import lmfe_pkg::*; (
  input  logic   clk,
  input  logic   RST,
  input  pixel_t pix,
  input  logic   in_en,
  output logic   out_valid,
  output pixel_t dout
);

  // update broadcast to all cells
  sort_update_t upd;

  // cell chain with a fixed entry at each end
  // chain[k+1] is cell k, chain[0] and chain[LMF_WIN+1] are the edges
  pixel_t       chain [`LMF_WIN+2];

  // value of the middle cell
  pixel_t       median;

  assign chain[0]          = `LMF_PIX_MIN;
  assign chain[`LMF_WIN+1] = `LMF_PIX_MAX;

  assign median = chain[`LMF_MED_IDX+1];

  // delay line and insert/delete source
  window_feeder u_feeder (
    .clk   (clk),
    .RST   (RST),
    .pix   (pix),
    .in_en (in_en),
    .upd   (upd)
  );

  // sorted list, ascending from cell 0
  for (genvar k = 0; k < `LMF_WIN; k++) begin : g_cell
    sort_cell u_cell (
      .clk   (clk),
      .RST   (RST),
      .upd   (upd),
      .prev  (chain[k]),
      .next  (chain[k+2]),
      .value (chain[k+1])
    );
  end

  // fill tracking and result register
  median_output u_out (
    .clk       (clk),
    .RST       (RST),
    .upd_en    (upd.en),
    .median    (median),
    .out_valid (out_valid),
    .dout      (dout)
  );

endmodule

//--- tb/lmfe_assertions.sv
// median filter port checks

`timescale 1ns/10ps

module lmfe_assertions import lmfe_pkg::*; (
  input logic   clk,
  input logic   RST,
  input logic   in_en,
  input logic   out_valid,
  input pixel_t dout
);

  // number of failed assertions
  int unsigned fail_cnt = 0;

  // pipeline is three edges deep, nothing can leave it sooner
  property quiet_after_reset;
    @(posedge clk) RST |=> !out_valid [*3];
  endproperty

  // every result comes from a pixel accepted three edges before
  property valid_has_source;
    @(posedge clk) disable iff (RST) out_valid |-> $past(in_en, 3);
  endproperty

  // result register only loads together with the strobe
  property dout_held;
    @(posedge clk) disable iff (RST) !out_valid |-> $stable(dout);
  endproperty

  a_quiet_after_reset : assert property (quiet_after_reset) else begin
    fail_cnt++;
    $error("out_valid went high within three cycles of reset");
  end

  a_valid_has_source : assert property (valid_has_source) else begin
    fail_cnt++;
    $error("out_valid without an accepted pixel three cycles before");
  end

  a_dout_held : assert property (dout_held) else begin
    fail_cnt++;
    $error("dout changed while out_valid was low");
  end

endmodule

//--- tb/lmfe_tb.sv
// running median filter testbench

`timescale 1ns/10ps

`include "lmfe_macros.svh"

module lmfe_tb import lmfe_pkg::*; ();

  localparam int CLK_HALF     = 10;
  localparam int RESET_CYC    = 8;
  localparam int CONST_PIX    = `LMF_WIN + 20;
  localparam int SPIKES       = 4;
  localparam int IMPULSE_PIX  = `LMF_WIN + SPIKES * (`LMF_WIN + 1);
  localparam int RAND_PIX     = 300;
  localparam int RAMP_LEN     = 128;
  localparam int RESTART_PIX  = 30 + `LMF_WIN - 1 + 20;
  localparam int TOTAL_PIX    = `LMF_WIN + CONST_PIX + IMPULSE_PIX + RAND_PIX +
                                2 * RAMP_LEN + RESTART_PIX;
  localparam int WATCHDOG_CYC = TOTAL_PIX * 4 + 500;
  localparam int DRAIN_LIMIT  = 16;

  // expected median and the edge it is due on
  typedef struct packed {
    logic [31:0] due;
    pixel_t      val;
  } expect_t;

  logic   clk;
  logic   RST;
  pixel_t pix;
  logic   in_en;
  logic   out_valid;
  pixel_t dout;

  // model window
  // newest sample at the front
  pixel_t      model_q [$];
  expect_t     exp_q [$];
  // medians seen on dout during the current test
  pixel_t      obs_q [$];
  int          model_fill = 0;
  int unsigned cycle = 0;

  int          value_errs = 0;
  int          timing_errs = 0;
  int unsigned seed_ret;

  lmfe_top UUT (
    .clk       (clk),
    .RST       (RST),
    .pix       (pix),
    .in_en     (in_en),
    .out_valid (out_valid),
    .dout      (dout)
  );

  bind lmfe_top lmfe_assertions u_chk (
    .clk       (clk),
    .RST       (RST),
    .in_en     (in_en),
    .out_valid (out_valid),
    .dout      (dout)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  // median of the model window
  // insertion sort on a copy
  function automatic pixel_t window_median();
    pixel_t s [`LMF_WIN];
    pixel_t t;
    int     j;
    for (int i = 0; i < `LMF_WIN; i++) begin
      s[i] = model_q[i];
    end
    for (int i = 1; i < `LMF_WIN; i++) begin
      t = s[i];
      j = i - 1;
      while (j >= 0 && s[j] > t) begin
        s[j+1] = s[j];
        j--;
      end
      s[j+1] = t;
    end
    return s[`LMF_MED_IDX];
  endfunction

  // empty window reads as all maximum pixels
  function automatic void restart_model();
    model_q.delete();
    for (int i = 0; i < `LMF_WIN; i++) begin
      model_q.push_back(`LMF_PIX_MAX);
    end
    exp_q.delete();
    model_fill = 0;
  endfunction

  function automatic void accept_pixel(input pixel_t p);
    expect_t e;
    model_q.push_front(p);
    void'(model_q.pop_back());
    if (model_fill < `LMF_WIN) begin
      model_fill++;
    end
    if (model_fill >= `LMF_WIN) begin
      e.due = cycle + 3;
      e.val = window_median();
      exp_q.push_back(e);
    end
  endfunction

  // model and cycle-exact compare
  // sampled on the rising edge
  always @(posedge clk) begin
    expect_t e;
    cycle = cycle + 1;
    if (RST) begin
      restart_model();
    end else begin
      if (out_valid) begin
        assert (exp_q.size() != 0) else begin
          timing_errs++;
          $display("out_valid was high at %0t with no result due", $time);
        end
        if (exp_q.size() != 0) begin
          e = exp_q.pop_front();
          assert (e.due == cycle) else begin
            timing_errs++;
            $display("result due on edge %0d came on edge %0d at %0t",
                     e.due, cycle, $time);
          end
          assert (dout == e.val) else begin
            value_errs++;
            $display("ERROR t=%0t dout: expected %0d got %0d", $time, e.val, dout);
          end
        end
        obs_q.push_back(dout);
      end else begin
        assert (exp_q.size() == 0 || exp_q[0].due > cycle) else begin
          timing_errs++;
          $display("out_valid missing at %0t for a result due on edge %0d",
                   $time, exp_q[0].due);
          void'(exp_q.pop_front());
        end
      end
      if (in_en) begin
        accept_pixel(pix);
      end
    end
  end

  task automatic send_pixel(input pixel_t p);
    @(posedge clk);
    pix   <= p;
    in_en <= 1'b1;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    in_en <= 1'b0;
  endtask

  // stop the stream and wait until every due result has shown up
  task automatic drain();
    int waited;
    waited = 0;
    idle_cycle();
    @(negedge clk);
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (exp_q.size() == 0) else begin
      timing_errs++;
      $display("results still missing %0d cycles after the stream stopped", DRAIN_LIMIT);
    end
  endtask

  task automatic check_count(input int n, input string what);
    assert (obs_q.size() == n) else begin
      timing_errs++;
      $display("%s gave %0d results where %0d were expected", what, obs_q.size(), n);
    end
  endtask

  task automatic check_all(input int first, input pixel_t v);
    for (int k = first; k < obs_q.size(); k++) begin
      assert (obs_q[k] == v) else begin
        value_errs++;
        $display("ERROR t=%0t dout: expected %0d got %0d", $time, v, obs_q[k]);
      end
    end
  endtask

  // first strobe only with the window-th pixel
  task automatic test_reset_fill();
    obs_q.delete();
    for (int i = 0; i < `LMF_WIN - 1; i++) begin
      send_pixel(pixel_t'($urandom));
    end
    drain();
    check_count(0, "partial window");
    send_pixel(pixel_t'($urandom));
    drain();
    check_count(1, "first full window");
  endtask

  task automatic test_constant(input pixel_t v);
    obs_q.delete();
    repeat (CONST_PIX) send_pixel(v);
    drain();
    check_count(CONST_PIX, "constant field");
    check_all(`LMF_WIN - 1, v);
  endtask

  // one spike per window never reaches the middle cell
  task automatic test_impulse();
    obs_q.delete();
    repeat (`LMF_WIN) send_pixel(pixel_t'(100));
    drain();
    obs_q.delete();
    for (int s = 0; s < SPIKES; s++) begin
      send_pixel(s[0] ? `LMF_PIX_MAX : `LMF_PIX_MIN);
      repeat (`LMF_WIN) send_pixel(pixel_t'(100));
    end
    drain();
    check_count(SPIKES * (`LMF_WIN + 1), "impulse field");
    check_all(0, pixel_t'(100));
  endtask

  task automatic test_random();
    int gap;
    obs_q.delete();
    for (int i = 0; i < RAND_PIX; i++) begin
      send_pixel(pixel_t'($urandom));
      gap = $urandom_range(2, 0);
      repeat (gap) idle_cycle();
    end
    drain();
    check_count(RAND_PIX, "random stream");
  endtask

  // median of a monotonic run is the sample from half a window back
  task automatic test_ramp(input bit up);
    pixel_t sent [RAMP_LEN];
    obs_q.delete();
    for (int k = 0; k < RAMP_LEN; k++) begin
      sent[k] = up ? pixel_t'(2 * k) : pixel_t'(254 - 2 * k);
      send_pixel(sent[k]);
    end
    drain();
    check_count(RAMP_LEN, up ? "rising ramp" : "falling ramp");
    for (int k = `LMF_WIN - 1; k < obs_q.size() && k < RAMP_LEN; k++) begin
      assert (obs_q[k] == sent[k - `LMF_MED_IDX]) else begin
        value_errs++;
        $display("ERROR t=%0t dout: expected %0d got %0d",
                 $time, sent[k - `LMF_MED_IDX], obs_q[k]);
      end
    end
  endtask

  task automatic test_restart();
    for (int i = 0; i < 30; i++) begin
      send_pixel(pixel_t'($urandom));
    end
    @(posedge clk);
    RST   <= 1'b1;
    in_en <= 1'b0;
    @(negedge clk);
    assert (!out_valid) else begin
      timing_errs++;
      $display("out_valid stayed high after reset was asserted");
    end
    repeat (RESET_CYC) @(posedge clk);
    RST <= 1'b0;
    obs_q.delete();
    for (int i = 0; i < `LMF_WIN - 1; i++) begin
      send_pixel(pixel_t'($urandom));
    end
    drain();
    check_count(0, "refill after reset");
    repeat (20) send_pixel(pixel_t'($urandom));
    drain();
    check_count(20, "stream after refill");
  endtask

  initial begin
    seed_ret = $urandom(55);
    RST   = 1'b1;
    pix   = '0;
    in_en = 1'b0;
    repeat (RESET_CYC) @(posedge clk);
    RST <= 1'b0;

    test_reset_fill();
    test_constant(pixel_t'(37));
    test_impulse();
    test_random();
    test_ramp(1'b1);
    test_ramp(1'b0);
    test_restart();

    repeat (4) @(posedge clk);
    $display("checks failed: values %0d, timing %0d, assertions %0d",
             value_errs, timing_errs, UUT.u_chk.fail_cnt);
    if (value_errs == 0 && timing_errs == 0 && UUT.u_chk.fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // run length bound
  // four cycles per pixel plus slack
  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYC);
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- lmfe.f
+incdir+src
src/lmfe_pkg.sv
src/window_feeder.sv
src/sort_cell.sv
src/median_output.sv
src/lmfe_top.sv
tb/lmfe_assertions.sv
tb/lmfe_tb.sv
